/* src.f */
+incdir+.
icache_pkg.sv
icache_array.sv
icache_ctrl.sv
main_mem.sv
icache_top.sv
tb_icache.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_icache
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

/* tb_icache.sv */
`default_nettype none

`include "icache_defs.svh"

module tb_icache;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 4;
    localparam int POOL_SIZE    = 6;
    localparam int RAND_OPS     = 48;
    localparam int TABLE_LEN    = 12;
    localparam int TOTAL_OPS    = TABLE_LEN + POOL_SIZE + RAND_OPS;

    // Idle, compare, write-back, the gap before the fill, allocate and the closing compare.
    localparam int DIRTY_MISS_CYCLES = 4 + 2 * (`MEM_LATENCY + 1);
    localparam int OP_BUDGET         = 2 * DIRTY_MISS_CYCLES + 2;
    localparam int WATCHDOG_TIME     =
        (RESET_CYCLES + 2 + TOTAL_OPS * OP_BUDGET + 50) * PERIOD;

    localparam logic [31:0] SEED = 32'h735a_cd8d;

    // One cycle in IDLE, ready in the COMPARE_TAG cycle.
    localparam int HIT_CYCLES = 2;

    typedef struct packed {
        logic                      wr;
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic [`ICACHE_DATA_W-1:0] wdata;
        logic [3:0]                exp_cycles;
    } step_t;

    // Operation, address, write data, expected cycles to ready (0 is unchecked).
    localparam step_t STEPS [TABLE_LEN] = '{
        '{1'b1, 12'h123, 32'hA5A5_0001, 4'd0},
        '{1'b0, 12'h123, 32'h0000_0000, 4'(HIT_CYCLES)},
        '{1'b0, 12'h123, 32'h0000_0000, 4'(HIT_CYCLES)},
        '{1'b1, 12'h3A7, 32'h1111_AAAA, 4'd0},
        '{1'b1, 12'h5C7, 32'h2222_BBBB, 4'd0},
        '{1'b0, 12'h3A7, 32'h0000_0000, 4'd0},
        '{1'b0, 12'h5C7, 32'h0000_0000, 4'd0},
        '{1'b1, 12'h5C7, 32'h3333_CCCC, 4'(HIT_CYCLES)},
        '{1'b0, 12'h5C7, 32'h0000_0000, 4'(HIT_CYCLES)},
        '{1'b0, 12'h123, 32'h0000_0000, 4'(HIT_CYCLES)},
        '{1'b0, 12'h3A7, 32'h0000_0000, 4'd0},
        '{1'b0, 12'h5C7, 32'h0000_0000, 4'd0}
    };

    // Two groups of addresses that collide on their index.
    localparam logic [`ICACHE_ADDR_W-1:0] POOL [POOL_SIZE] = '{
        12'h105, 12'h205, 12'h305, 12'h405, 12'h01B, 12'hF0B
    };

    logic                      clk;
    logic                      rst;
    logic [`ICACHE_ADDR_W-1:0] cpu_req_addr;
    logic                      cpu_req_valid;
    logic                      cpu_req_wr;
    logic [`ICACHE_DATA_W-1:0] cpu_req_wdata;
    wire  [`ICACHE_DATA_W-1:0] cpu_req_data;
    wire                       cpu_req_ready;

    logic [`ICACHE_DATA_W-1:0] shadow [0:(1 << `ICACHE_ADDR_W)-1];

    icache_top u_icache_top (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_wr    (cpu_req_wr),
        .cpu_req_wdata (cpu_req_wdata),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Holds the request until the ready pulse, then drops valid for a cycle.
    task automatic run_op(input logic wr, input logic [`ICACHE_ADDR_W-1:0] addr,
                          input logic [`ICACHE_DATA_W-1:0] wdata, input int exp_cycles);
        int                        cycles;
        logic [`ICACHE_DATA_W-1:0] got;
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b1;
        cpu_req_wr    = wr;
        cpu_req_addr  = addr;
        cpu_req_wdata = wdata;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        while (cpu_req_ready !== 1'b1);
        got = cpu_req_data;
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b0;
        cpu_req_wr    = 1'b0;
        if (wr)
        begin
            shadow[addr] = wdata;
        end
        else
        begin
            check_value("cpu_req_data", got, shadow[addr]);
        end
        if (exp_cycles != 0)
        begin
            check_value("cpu_req_ready latency", cycles, exp_cycles);
        end
    endtask

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Timeout: a request got no cpu_req_ready within %0d time units",
                 WATCHDOG_TIME);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        int                        i;
        int                        k;
        logic                      wr;
        logic [`ICACHE_DATA_W-1:0] wdata;
        rst           = 1'b1;
        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        cpu_req_wr    = 1'b0;
        cpu_req_wdata = '0;
        void'($urandom(SEED));

        for (i = 0; i < RESET_CYCLES - 1; i++)
        begin
            @(negedge clk);
            check_value("cpu_req_ready", 32'(cpu_req_ready), 32'h0);
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("cpu_req_ready", 32'(cpu_req_ready), 32'h0);

        for (i = 0; i < TABLE_LEN; i++)
        begin
            run_op(STEPS[i].wr, STEPS[i].addr, STEPS[i].wdata, int'(STEPS[i].exp_cycles));
        end

        // Every pool address is written before random reads.
        for (i = 0; i < POOL_SIZE; i++)
        begin
            wdata = $urandom;
            run_op(1'b1, POOL[i], wdata, 0);
        end

        for (i = 0; i < RAND_OPS; i++)
        begin
            k     = int'($urandom_range(POOL_SIZE - 1, 0));
            wr    = 1'($urandom_range(1, 0));
            wdata = $urandom;
            run_op(wr, POOL[k], wdata, 0);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* icache_top.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [`ICACHE_ADDR_W-1:0]   cpu_req_addr,
    input  wire                        cpu_req_valid,
    input  wire                        cpu_req_wr,
    input  wire [`ICACHE_DATA_W-1:0]   cpu_req_wdata,
    output wire [`ICACHE_DATA_W-1:0]   cpu_req_data,
    output wire                        cpu_req_ready
);

    wire [`ICACHE_INDEX_W-1:0]     rd_index;
    wire icache_pkg::cache_entry_t rd_entry;
    wire                           wr_en;
    wire [`ICACHE_INDEX_W-1:0]     wr_index;
    wire icache_pkg::cache_entry_t wr_entry;

    wire                           mem_req_valid;
    wire                           mem_req_wr;
    wire [`ICACHE_ADDR_W-1:0]      mem_req_addr;
    wire [`ICACHE_DATA_W-1:0]      mem_wr_data;
    wire [`ICACHE_DATA_W-1:0]      mem_req_data;
    wire                           mem_req_ready;

    icache_ctrl u_icache_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_wr    (cpu_req_wr),
        .cpu_req_wdata (cpu_req_wdata),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .rd_index      (rd_index),
        .rd_entry      (rd_entry),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_entry      (wr_entry),
        .mem_req_valid (mem_req_valid),
        .mem_req_wr    (mem_req_wr),
        .mem_req_addr  (mem_req_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

    icache_array u_icache_array (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .rd_entry (rd_entry),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry)
    );

    main_mem u_main_mem (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req_wr    (mem_req_wr),
        .mem_req_addr  (mem_req_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

endmodule

`default_nettype wire

/* main_mem.sv */
`default_nettype none

`include "icache_defs.svh"

module main_mem (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        mem_req_valid,
    input  wire                        mem_req_wr,
    input  wire [`ICACHE_ADDR_W-1:0]   mem_req_addr,
    input  wire [`ICACHE_DATA_W-1:0]   mem_wr_data,
    output logic [`ICACHE_DATA_W-1:0]  mem_req_data,
    output logic                       mem_req_ready
);

    localparam int WORDS = 1 << `ICACHE_ADDR_W;
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [`ICACHE_DATA_W-1:0] mem [0:WORDS-1];
    logic                      busy;
    logic [CNT_W-1:0]          cnt;

    assign mem_req_ready = busy && (cnt == CNT_W'(`MEM_LATENCY));

    // Count starts at one in the cycle after the request is seen.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            cnt  <= '0;
        end
        else if (!busy)
        begin
            if (mem_req_valid)
            begin
                busy <= 1'b1;
                cnt  <= CNT_W'(1);
            end
        end
        else if (mem_req_ready)
        begin
            busy <= 1'b0;
            cnt  <= '0;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    // Address is held, so the read word is ready by the pulse.
    always_ff @(posedge clk)
    begin
        if (mem_req_valid)
        begin
            mem_req_data <= mem[mem_req_addr];
        end
        if (mem_req_ready && mem_req_wr)
        begin
            mem[mem_req_addr] <= mem_wr_data;
        end
    end

endmodule

`default_nettype wire

/* icache_ctrl.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_ctrl (
    input  wire                             clk,
    input  wire                             rst,

    input  wire [`ICACHE_ADDR_W-1:0]        cpu_req_addr,
    input  wire                             cpu_req_valid,
    input  wire                             cpu_req_wr,
    input  wire [`ICACHE_DATA_W-1:0]        cpu_req_wdata,
    output logic [`ICACHE_DATA_W-1:0]       cpu_req_data,
    output logic                            cpu_req_ready,

    output logic [`ICACHE_INDEX_W-1:0]      rd_index,
    input  wire icache_pkg::cache_entry_t   rd_entry,
    output logic                            wr_en,
    output logic [`ICACHE_INDEX_W-1:0]      wr_index,
    output icache_pkg::cache_entry_t        wr_entry,

    output logic                            mem_req_valid,
    output logic                            mem_req_wr,
    output logic [`ICACHE_ADDR_W-1:0]       mem_req_addr,
    output logic [`ICACHE_DATA_W-1:0]       mem_wr_data,
    input  wire [`ICACHE_DATA_W-1:0]        mem_req_data,
    input  wire                             mem_req_ready
);

    icache_pkg::cache_state_t state;
    icache_pkg::cache_state_t next_state;

    logic [`ICACHE_ADDR_W-1:0] req_addr;
    logic                      req_wr;
    logic [`ICACHE_DATA_W-1:0] req_wdata;
    logic [`ICACHE_TAG_W-1:0]  req_tag;
    logic                      hit;

    assign req_tag  = req_addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W];
    assign rd_index = req_addr[`ICACHE_INDEX_W-1:0];
    assign wr_index = rd_index;
    assign hit      = rd_entry.valid && (rd_entry.tag == req_tag);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= icache_pkg::IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // Request is captured on the way out of IDLE.
    always_ff @(posedge clk)
    begin
        if (state == icache_pkg::IDLE && cpu_req_valid)
        begin
            req_addr  <= cpu_req_addr;
            req_wr    <= cpu_req_wr;
            req_wdata <= cpu_req_wdata;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            icache_pkg::IDLE:
            begin
                if (cpu_req_valid)
                begin
                    next_state = icache_pkg::COMPARE_TAG;
                end
            end
            icache_pkg::COMPARE_TAG:
            begin
                if (hit)
                begin
                    next_state = icache_pkg::IDLE;
                end
                else if (rd_entry.valid && rd_entry.dirty)
                begin
                    next_state = icache_pkg::WRITE_BACK;
                end
                else
                begin
                    next_state = icache_pkg::ALLOCATE;
                end
            end
            icache_pkg::WRITE_BACK:
            begin
                if (mem_req_ready)
                begin
                    next_state = icache_pkg::ALLOCATE;
                end
            end
            icache_pkg::ALLOCATE:
            begin
                if (mem_req_ready)
                begin
                    next_state = icache_pkg::COMPARE_TAG;
                end
            end
            default:
            begin
                next_state = icache_pkg::IDLE;
            end
        endcase
    end

    assign cpu_req_ready = (state == icache_pkg::COMPARE_TAG) && hit;
    assign cpu_req_data  = rd_entry.data;

    // Write hit marks the line dirty; a fill installs a clean line.
    always_comb
    begin
        wr_en    = 1'b0;
        wr_entry = rd_entry;
        if (state == icache_pkg::COMPARE_TAG && hit && req_wr)
        begin
            wr_en          = 1'b1;
            wr_entry.dirty = 1'b1;
            wr_entry.data  = req_wdata;
        end
        else if (state == icache_pkg::ALLOCATE && mem_req_ready)
        begin
            wr_en          = 1'b1;
            wr_entry.valid = 1'b1;
            wr_entry.dirty = 1'b0;
            wr_entry.tag   = req_tag;
            wr_entry.data  = mem_req_data;
        end
    end

    // Victim address is its own tag over the request index.
    assign mem_req_wr   = (state == icache_pkg::WRITE_BACK);
    assign mem_req_addr = mem_req_wr ? {rd_entry.tag, rd_index} : req_addr;
    assign mem_wr_data  = rd_entry.data;

    // Valid drops for one cycle after every ready pulse.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_valid <= 1'b0;
        end
        else if (mem_req_ready)
        begin
            mem_req_valid <= 1'b0;
        end
        else if (next_state == icache_pkg::WRITE_BACK || next_state == icache_pkg::ALLOCATE)
        begin
            mem_req_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* icache_array.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_array (
    input  wire                             clk,
    input  wire                             rst,
    input  wire [`ICACHE_INDEX_W-1:0]       rd_index,
    output icache_pkg::cache_entry_t        rd_entry,
    input  wire                             wr_en,
    input  wire [`ICACHE_INDEX_W-1:0]       wr_index,
    input  wire icache_pkg::cache_entry_t   wr_entry
);

    icache_pkg::cache_entry_t entries [0:`ICACHE_SETS-1];

    // Per-set valid bits.
    logic [`ICACHE_SETS-1:0] valid_q;

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            entries[wr_index] <= wr_entry;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else if (wr_en)
        begin
            valid_q[wr_index] <= wr_entry.valid;
        end
    end

    // Asynchronous read, valid taken from the flop vector.
    always_comb
    begin
        rd_entry       = entries[rd_index];
        rd_entry.valid = valid_q[rd_index];
    end

endmodule

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE_TAG,
        WRITE_BACK,
        ALLOCATE
    } cache_state_t;

    // Valid, dirty, tag and data of one line.
    typedef struct packed {
        logic                      valid;
        logic                      dirty;
        logic [`ICACHE_TAG_W-1:0]  tag;
        logic [`ICACHE_DATA_W-1:0] data;
    } cache_entry_t;

endpackage

`default_nettype wire

/* icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Word address is tag above index.
`define ICACHE_ADDR_W  12
`define ICACHE_INDEX_W 4
`define ICACHE_TAG_W   (`ICACHE_ADDR_W - `ICACHE_INDEX_W)

`define ICACHE_DATA_W  32

// One word per line, direct mapped.
`define ICACHE_SETS    16

// Cycles from the first valid cycle to the ready pulse.
`define MEM_LATENCY    3

`endif
